/* rtl/ex_stage_macros.svh */
//////////////////////////////////////////////////////////////////////
// Widths shared by the execute stage and its testbench
// RV32 only; register addresses span integer and FP register files
//////////////////////////////////////////////////////////////////////

`ifndef EX_STAGE_MACROS_SVH
`define EX_STAGE_MACROS_SVH

// Data path width
`define EX_XLEN 32

// Register address, bit 5 selects the FP register file
`define EX_RADDR_W 6

// Shift amount taken from operand b
`define EX_SHAMT_W 5

// Cycles of a MULH, MULHSU or MULHU
`define EX_MULH_PHASES 4

`endif

/* rtl/ex_op_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Opcodes and request bundles from decode into the ALU and multiplier
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_stage_macros.svh"

package ex_op_pkg;

  // ALU opcodes, comparisons grouped at the end
  typedef enum logic [4:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLL,
    SRL,
    SRA,
    SLT,
    SLTU,
    EQ,
    NE,
    LT,
    GE,
    LTU,
    GEU
  } alu_op_e;

  // Multiplier opcodes
  typedef enum logic [1:0] {
    MUL,
    MULH,
    MULHSU,
    MULHU
  } mult_op_e;

  // ALU request, 70 bits
  typedef struct packed {
    logic               en;
    alu_op_e            op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
  } alu_req_t;

  // Multiplier request, 67 bits
  typedef struct packed {
    logic               en;
    mult_op_e           op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
  } mult_req_t;

endpackage

`default_nettype wire

/* rtl/ex_wb_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Register-file write bundle and decode-side control for write-back
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "ex_stage_macros.svh"

package ex_wb_pkg;

  // One register-file write port, 39 bits
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } rf_wr_t;

  // Control from decode, 17 bits
  typedef struct packed {
    // ALU / forwarding port
    logic                   regfile_alu_we;
    logic [`EX_RADDR_W-1:0] regfile_alu_waddr;
    // LSU port, carried to WB
    logic                   regfile_we;
    logic [`EX_RADDR_W-1:0] regfile_waddr;
    logic                   csr_access;
    logic                   lsu_en;
    logic                   branch_in_ex;
  } ex_ctrl_t;

endpackage

`default_nettype wire

/* rtl/ex_alu.sv */
//////////////////////////////////////////////////////////////////////
// Single-cycle integer ALU, purely combinational
// Comparisons return 0 or 1; cmp_result_o feeds the branch decision
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ex_stage_macros.svh"

module ex_alu (
  input  ex_op_pkg::alu_req_t  alu_req_i,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_result_o
);

  // Shift amount from low bits of b
  logic [`EX_SHAMT_W-1:0] shamt;
  // Signed views of the operands
  logic signed [`EX_XLEN-1:0] a_s;
  logic signed [`EX_XLEN-1:0] b_s;
  // Comparison bit
  logic cmp_bit;

  assign shamt = alu_req_i.b[`EX_SHAMT_W-1:0];
  assign a_s   = $signed(alu_req_i.a);
  assign b_s   = $signed(alu_req_i.b);

  //////////////////////////////////////////////////////////////////////
  // Comparator
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cmp_bit = 1'b0;
    case (alu_req_i.op)
      ex_op_pkg::SLT,
      ex_op_pkg::LT:   cmp_bit = (a_s < b_s);
      ex_op_pkg::SLTU,
      ex_op_pkg::LTU:  cmp_bit = (alu_req_i.a < alu_req_i.b);
      ex_op_pkg::GE:   cmp_bit = (a_s >= b_s);
      ex_op_pkg::GEU:  cmp_bit = (alu_req_i.a >= alu_req_i.b);
      ex_op_pkg::EQ:   cmp_bit = (alu_req_i.a == alu_req_i.b);
      ex_op_pkg::NE:   cmp_bit = (alu_req_i.a != alu_req_i.b);
      // Not a comparison
      default: ;
    endcase
  end

  // Zero for arithmetic and logic ops
  assign cmp_result_o = cmp_bit;

  //////////////////////////////////////////////////////////////////////
  // Result mux
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result_o = '0;
    case (alu_req_i.op)
      ex_op_pkg::ADD: result_o = alu_req_i.a + alu_req_i.b;
      ex_op_pkg::SUB: result_o = alu_req_i.a - alu_req_i.b;
      ex_op_pkg::AND: result_o = alu_req_i.a & alu_req_i.b;
      ex_op_pkg::OR:  result_o = alu_req_i.a | alu_req_i.b;
      ex_op_pkg::XOR: result_o = alu_req_i.a ^ alu_req_i.b;
      ex_op_pkg::SLL: result_o = alu_req_i.a << shamt;
      ex_op_pkg::SRL: result_o = alu_req_i.a >> shamt;
      // Arithmetic shift keeps the sign
      ex_op_pkg::SRA: result_o = $unsigned(a_s >>> shamt);
      // All comparisons land in bit 0
      default: begin
        result_o[0] = cmp_result_o;
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ex_mult.sv */
//////////////////////////////////////////////////////////////////////
// MUL in one cycle; MULH/MULHSU/MULHU over four 16x16 partial products
// Request must stay stable until the P3 cycle with ex_ready_i high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ex_stage_macros.svh"

module ex_mult (
  input  logic                  clk,
  input  logic                  rst_n,
  input  ex_op_pkg::mult_req_t  mult_req_i,
  input  logic                  ex_ready_i,
  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  ready_o,
  output logic                  multicycle_o
);

  localparam int unsigned HALF_W = `EX_XLEN / 2;

  // One state per phase of a high multiply
  typedef enum logic [$clog2(`EX_MULH_PHASES)-1:0] {
    IDLE,
    P1,
    P2,
    P3
  } phase_e;

  phase_e state_q;
  phase_e state_nxt;

  logic                    mulh_req;
  logic [`EX_XLEN-1:0]     prod_lo;
  // Partial product operands and result
  logic [HALF_W-1:0]       pp_a;
  logic [HALF_W-1:0]       pp_b;
  logic [`EX_XLEN-1:0]     pp;
  logic [2*`EX_XLEN-1:0]   pp_shifted;
  // Accumulator, payload only
  logic [2*`EX_XLEN-1:0]   acc_q;
  logic [2*`EX_XLEN-1:0]   acc_sum;
  logic                    acc_load;
  // Sign correction for the high word
  logic                    a_neg;
  logic                    b_neg;
  logic [`EX_XLEN-1:0]     hi_word;

  assign mulh_req = mult_req_i.en & (mult_req_i.op != ex_op_pkg::MUL);

  // Low word, single cycle
  assign prod_lo = mult_req_i.a * mult_req_i.b;

  //////////////////////////////////////////////////////////////////////
  // Partial product select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    pp_a = mult_req_i.a[HALF_W-1:0];
    pp_b = mult_req_i.b[HALF_W-1:0];
    case (state_q)
      P1: pp_b = mult_req_i.b[`EX_XLEN-1:HALF_W];
      P2: pp_a = mult_req_i.a[`EX_XLEN-1:HALF_W];
      P3: begin
        pp_a = mult_req_i.a[`EX_XLEN-1:HALF_W];
        pp_b = mult_req_i.b[`EX_XLEN-1:HALF_W];
      end
      default: ;
    endcase
  end

  assign pp = pp_a * pp_b;

  // Cross terms at 16, high x high at 32
  always_comb begin
    case (state_q)
      IDLE:    pp_shifted = {{`EX_XLEN{1'b0}}, pp};
      P3:      pp_shifted = {pp, {`EX_XLEN{1'b0}}};
      default: pp_shifted = {{HALF_W{1'b0}}, pp, {HALF_W{1'b0}}};
    endcase
  end

  // Fresh start in IDLE
  assign acc_sum  = ((state_q == IDLE) ? '0 : acc_q) + pp_shifted;
  assign acc_load = (state_q == P1) | (state_q == P2) | ((state_q == IDLE) & mulh_req);

  always_ff @(posedge clk) begin
    if (acc_load) begin
      acc_q <= acc_sum;
    end
  end

  // Negative operands seen as unsigned add 2^32 * other operand
  assign a_neg   = mult_req_i.a[`EX_XLEN-1] &
                   ((mult_req_i.op == ex_op_pkg::MULH) | (mult_req_i.op == ex_op_pkg::MULHSU));
  assign b_neg   = mult_req_i.b[`EX_XLEN-1] & (mult_req_i.op == ex_op_pkg::MULH);
  assign hi_word = acc_sum[2*`EX_XLEN-1:`EX_XLEN]
                   - (a_neg ? mult_req_i.b : '0)
                   - (b_neg ? mult_req_i.a : '0);

  assign result_o = (mult_req_i.op == ex_op_pkg::MUL) ? prod_lo : hi_word;

  //////////////////////////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state_q;
    case (state_q)
      IDLE:    if (mulh_req) state_nxt = P1;
      P1:      state_nxt = P2;
      P2:      state_nxt = P3;
      // Hold under back-pressure
      P3:      if (ex_ready_i) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  assign ready_o      = (state_q == P3) | ((state_q == IDLE) & ~mulh_req);
  assign multicycle_o = (state_q != IDLE);

  // Decode must hold the request through all phases
  a_mulh_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != IDLE) |-> ($stable(mult_req_i.op) && $stable(mult_req_i.a) &&
                           $stable(mult_req_i.b)));

endmodule

`default_nettype wire

/* rtl/ex_commit.sv */
//////////////////////////////////////////////////////////////////////
// Forwarding mux, EX/WB register for the LSU port and stall control
// Enables of ALU, multiplier and CSR are expected mutually exclusive
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ex_stage_macros.svh"

module ex_commit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  ex_wb_pkg::ex_ctrl_t  ctrl_i,
  input  logic                 alu_en_i,
  input  logic                 mult_en_i,
  input  logic [`EX_XLEN-1:0]  alu_result_i,
  input  logic [`EX_XLEN-1:0]  mult_result_i,
  input  logic [`EX_XLEN-1:0]  csr_rdata_i,
  input  logic [`EX_XLEN-1:0]  lsu_rdata_i,
  input  logic                 alu_ready_i,
  input  logic                 mult_ready_i,
  input  logic                 lsu_ready_ex_i,
  input  logic                 wb_ready_i,
  output ex_wb_pkg::rf_wr_t    fwd_o,
  output ex_wb_pkg::rf_wr_t    wb_o,
  output logic                 ex_ready_o,
  output logic                 ex_valid_o
);

  // All units and WB able to finish this cycle
  logic units_done;
  // LSU port EX/WB register
  logic                   wb_we_q;
  logic [`EX_RADDR_W-1:0] wb_waddr_q;

  //////////////////////////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    fwd_o.we    = ctrl_i.regfile_alu_we;
    fwd_o.waddr = ctrl_i.regfile_alu_waddr;
    // CSR first, then multiplier, then ALU
    if (ctrl_i.csr_access) begin
      fwd_o.wdata = csr_rdata_i;
    end else if (mult_en_i) begin
      fwd_o.wdata = mult_result_i;
    end else if (alu_en_i) begin
      fwd_o.wdata = alu_result_i;
    end else begin
      fwd_o.wdata = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stall control
  //////////////////////////////////////////////////////////////////////

  assign units_done = alu_ready_i & mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve here, so they never wait for WB
  assign ex_ready_o = units_done | ctrl_i.branch_in_ex;

  // Independent of ex_ready_o
  assign ex_valid_o = (alu_en_i | mult_en_i | ctrl_i.csr_access | ctrl_i.lsu_en) &
                      units_done;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q    <= 1'b0;
      wb_waddr_q <= '0;
    end else if (ex_valid_o) begin
      wb_we_q <= ctrl_i.regfile_we;
      // Address kept from last real write
      if (ctrl_i.regfile_we) begin
        wb_waddr_q <= ctrl_i.regfile_waddr;
      end
    end else if (wb_ready_i) begin
      // WB free but nothing issued, flush a bubble
      wb_we_q <= 1'b0;
    end
  end

  // Load data comes straight from the LSU
  assign wb_o.we    = wb_we_q;
  assign wb_o.waddr = wb_waddr_q;
  assign wb_o.wdata = lsu_rdata_i;

  // Decode drives at most one result source
  a_one_source : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_en_i, mult_en_i, ctrl_i.csr_access}));

  // No stray write on release of reset
  a_wb_we_after_reset : assert property (@(posedge clk)
    $rose(rst_n) |-> !wb_o.we);

endmodule

`default_nettype wire

/* rtl/ex_stage.sv */
//////////////////////////////////////////////////////////////////////
// Integer execute stage top; ALU, multiplier and commit logic
// Decode holds its inputs while ex_ready_o is low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ex_stage_macros.svh"

module ex_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  // Requests and control from decode
  input  ex_op_pkg::alu_req_t  alu_req_i,
  input  ex_op_pkg::mult_req_t mult_req_i,
  input  ex_wb_pkg::ex_ctrl_t  ctrl_i,
  input  logic [`EX_XLEN-1:0]  csr_rdata_i,
  input  logic [`EX_XLEN-1:0]  lsu_rdata_i,
  input  logic                 lsu_ready_ex_i,
  input  logic                 wb_ready_i,
  // Write ports
  output ex_wb_pkg::rf_wr_t    fwd_o,
  output ex_wb_pkg::rf_wr_t    wb_o,
  // Branch and stall
  output logic                 branch_decision_o,
  output logic                 mult_multicycle_o,
  output logic                 ex_ready_o,
  output logic                 ex_valid_o
);

  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;

  // ALU, comparison drives the branch decision
  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  // Multiplier, released by the stage ready
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .mult_req_i   (mult_req_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  // ALU always finishes in one cycle
  ex_commit u_commit (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_i         (ctrl_i),
    .alu_en_i       (alu_req_i.en),
    .mult_en_i      (mult_req_i.en),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .csr_rdata_i    (csr_rdata_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .alu_ready_i    (1'b1),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .fwd_o          (fwd_o),
    .wb_o           (wb_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

`default_nettype wire

/* testbench/tb_ex_model.svh */
//////////////////////////////////////////////////////////////////////
// Reference model of ALU, branch compare and multiplier, RV32 rules
//////////////////////////////////////////////////////////////////////

`ifndef TB_EX_MODEL_SVH
`define TB_EX_MODEL_SVH

// Branch compare, 0 for non-comparison opcodes
function automatic logic cmp_model(ex_op_pkg::alu_op_e op, logic [`EX_XLEN-1:0] a,
                                   logic [`EX_XLEN-1:0] b);
  case (op)
    ex_op_pkg::SLT, ex_op_pkg::LT:   return $signed(a) < $signed(b);
    ex_op_pkg::SLTU, ex_op_pkg::LTU: return a < b;
    ex_op_pkg::GE:                   return $signed(a) >= $signed(b);
    ex_op_pkg::GEU:                  return a >= b;
    ex_op_pkg::EQ:                   return a == b;
    ex_op_pkg::NE:                   return a != b;
    default:                         return 1'b0;
  endcase
endfunction

function automatic logic [`EX_XLEN-1:0] alu_model(ex_op_pkg::alu_op_e op,
                                                  logic [`EX_XLEN-1:0] a,
                                                  logic [`EX_XLEN-1:0] b);
  logic [`EX_SHAMT_W-1:0] sh;
  sh = b[`EX_SHAMT_W-1:0];
  case (op)
    ex_op_pkg::ADD: return a + b;
    ex_op_pkg::SUB: return a - b;
    ex_op_pkg::AND: return a & b;
    ex_op_pkg::OR:  return a | b;
    ex_op_pkg::XOR: return a ^ b;
    ex_op_pkg::SLL: return a << sh;
    ex_op_pkg::SRL: return a >> sh;
    // Logical shift, then fill the vacated top bits with the sign
    ex_op_pkg::SRA: return (a >> sh) | (~({`EX_XLEN{1'b1}} >> sh) & {`EX_XLEN{a[`EX_XLEN-1]}});
    default:        return {{(`EX_XLEN-1){1'b0}}, cmp_model(op, a, b)};
  endcase
endfunction

// Word of the full product, operands extended per opcode signedness
function automatic logic [`EX_XLEN-1:0] mul_model(ex_op_pkg::mult_op_e op,
                                                  logic [`EX_XLEN-1:0] a,
                                                  logic [`EX_XLEN-1:0] b);
  logic                  a_sgn;
  logic                  b_sgn;
  logic [2*`EX_XLEN-1:0] prod;
  a_sgn = (op == ex_op_pkg::MULH) || (op == ex_op_pkg::MULHSU);
  b_sgn = (op == ex_op_pkg::MULH);
  prod  = {{`EX_XLEN{a_sgn & a[`EX_XLEN-1]}}, a} * {{`EX_XLEN{b_sgn & b[`EX_XLEN-1]}}, b};
  return (op == ex_op_pkg::MUL) ? prod[`EX_XLEN-1:0] : prod[2*`EX_XLEN-1:`EX_XLEN];
endfunction

`endif

/* testbench/tb_ex_stage.sv */
//////////////////////////////////////////////////////////////////////
// Random ops from a fixed seed, every cycle checked at the falling edge
// LSU always ready; wb_ready_i toggles only in stall runs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "ex_stage_macros.svh"

module tb_ex_stage;

  localparam int TIMEOUT_CYC = 64;

  logic                 clk;
  logic                 rst_n;
  ex_op_pkg::alu_req_t  alu_req_i;
  ex_op_pkg::mult_req_t mult_req_i;
  ex_wb_pkg::ex_ctrl_t  ctrl_i;
  logic [`EX_XLEN-1:0]  csr_rdata_i;
  logic [`EX_XLEN-1:0]  lsu_rdata_i;
  logic                 lsu_ready_ex_i;
  logic                 wb_ready_i;
  ex_wb_pkg::rf_wr_t    fwd_o;
  ex_wb_pkg::rf_wr_t    wb_o;
  logic                 branch_decision_o;
  logic                 mult_multicycle_o;
  logic                 ex_ready_o;
  logic                 ex_valid_o;

  integer seed;
  int     checks;
  int     errors;
  logic   timed_out;
  // Expected EX/WB register
  logic                   wb_exp_we;
  logic [`EX_RADDR_W-1:0] wb_exp_waddr;

  `include "tb_ex_model.svh"

  ex_stage u_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req_i),
    .mult_req_i        (mult_req_i),
    .ctrl_i            (ctrl_i),
    .csr_rdata_i       (csr_rdata_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .wb_ready_i        (wb_ready_i),
    .fwd_o             (fwd_o),
    .wb_o              (wb_o),
    .branch_decision_o (branch_decision_o),
    .mult_multicycle_o (mult_multicycle_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string what, input logic [`EX_XLEN-1:0] got,
                         input logic [`EX_XLEN-1:0] want);
    checks++;
    assert (got == want) else begin
      errors++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // Stall outputs and WB port, then step the EX/WB model
  task automatic cycle_check(input logic exp_ready, input logic exp_valid, input logic exp_mc);
    compare("ex_ready_o", 32'(ex_ready_o), 32'(exp_ready));
    compare("ex_valid_o", 32'(ex_valid_o), 32'(exp_valid));
    compare("mult_multicycle_o", 32'(mult_multicycle_o), 32'(exp_mc));
    compare("wb_o.we", 32'(wb_o.we), 32'(wb_exp_we));
    compare("wb_o.waddr", 32'(wb_o.waddr), 32'(wb_exp_waddr));
    compare("wb_o.wdata", wb_o.wdata, lsu_rdata_i);
    if (exp_valid) begin
      wb_exp_we = ctrl_i.regfile_we;
      if (ctrl_i.regfile_we) begin
        wb_exp_waddr = ctrl_i.regfile_waddr;
      end
    end else if (wb_ready_i) begin
      wb_exp_we = 1'b0;
    end
  endtask

  // Hold the op until ex_ready_o, one check set per cycle
  task automatic run_op(input logic is_mulh, input logic stall,
                        input logic [`EX_XLEN-1:0] exp_data, input logic exp_cmp);
    int   cyc;
    logic units;
    logic done;
    cyc  = 0;
    done = 1'b0;
    while (!done && !timed_out) begin
      @(negedge clk);
      // High multiply is ready only from its last phase on
      units = wb_ready_i & lsu_ready_ex_i & (!is_mulh || cyc >= `EX_MULH_PHASES - 1);
      cycle_check(units | ctrl_i.branch_in_ex, units, is_mulh && cyc > 0);
      compare("branch_decision_o", 32'(branch_decision_o), 32'(exp_cmp));
      if (units) begin
        compare("fwd_o.wdata", fwd_o.wdata, exp_data);
        compare("fwd_o.we", 32'(fwd_o.we), 32'(ctrl_i.regfile_alu_we));
        compare("fwd_o.waddr", 32'(fwd_o.waddr), 32'(ctrl_i.regfile_alu_waddr));
      end
      if (ex_ready_o) begin
        done = 1'b1;
      end else if (cyc == TIMEOUT_CYC) begin
        $display("Timeout at %0t ns: ex_ready_o stayed low for %0d cycles", $time, cyc);
        timed_out = 1'b1;
      end else begin
        @(posedge clk);
        wb_ready_i  <= stall ? ($random(seed) % 4 != 0) : 1'b1;
        lsu_rdata_i <= $random(seed);
        cyc++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Corner values mixed into random operands
  function automatic logic [`EX_XLEN-1:0] pick_operand();
    logic [31:0] r;
    r = $random(seed);
    case (r[2:0])
      3'd0:    return 32'h8000_0000;
      3'd1:    return 32'hFFFF_FFFF;
      3'd2:    return 32'h7FFF_FFFF;
      3'd3:    return 32'h0000_0001;
      default: return $random(seed);
    endcase
  endfunction

  // Rising edge with fresh control; caller then sets one request
  task automatic start_op(input logic stall, input logic csr, input logic branch);
    logic [31:0] r;
    @(posedge clk);
    r = $random(seed);
    ctrl_i.regfile_alu_we    <= r[0];
    ctrl_i.regfile_alu_waddr <= r[6:1];
    ctrl_i.regfile_we        <= r[7];
    ctrl_i.regfile_waddr     <= r[13:8];
    ctrl_i.lsu_en            <= r[14];
    ctrl_i.csr_access        <= csr;
    ctrl_i.branch_in_ex      <= branch;
    lsu_rdata_i <= $random(seed);
    wb_ready_i  <= stall ? ($random(seed) % 4 != 0) : 1'b1;
    alu_req_i   <= '0;
    mult_req_i  <= '0;
  endtask

  task automatic alu_op(input logic stall, input logic branch);
    logic [31:0]         r;
    ex_op_pkg::alu_op_e  op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    r  = $random(seed);
    op = ex_op_pkg::alu_op_e'({1'b0, r[3:0]});
    a  = pick_operand();
    b  = pick_operand();
    start_op(stall, 1'b0, branch);
    alu_req_i <= '{en: 1'b1, op: op, a: a, b: b};
    run_op(1'b0, stall, alu_model(op, a, b), cmp_model(op, a, b));
  endtask

  task automatic mult_op(input logic stall);
    logic [31:0]         r;
    ex_op_pkg::mult_op_e op;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    r  = $random(seed);
    op = ex_op_pkg::mult_op_e'(r[1:0]);
    a  = pick_operand();
    b  = pick_operand();
    start_op(stall, 1'b0, 1'b0);
    mult_req_i <= '{en: 1'b1, op: op, a: a, b: b};
    run_op(op != ex_op_pkg::MUL, stall, mul_model(op, a, b), 1'b0);
  endtask

  task automatic csr_op(input logic stall);
    logic [`EX_XLEN-1:0] d;
    d = $random(seed);
    start_op(stall, 1'b1, 1'b0);
    csr_rdata_i <= d;
    run_op(1'b0, stall, d, 1'b0);
  endtask

  task automatic report(input string name, input int c0, input int e0);
    $display("Test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
  endtask

  initial begin
    int          c0;
    int          e0;
    logic [31:0] r;
    seed      = 91;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    wb_exp_we    = 1'b0;
    wb_exp_waddr = '0;
    rst_n          <= 1'b0;
    alu_req_i      <= '0;
    mult_req_i     <= '0;
    ctrl_i         <= '0;
    csr_rdata_i    <= '0;
    lsu_rdata_i    <= '0;
    lsu_ready_ex_i <= 1'b1;
    wb_ready_i     <= 1'b1;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Idle cycle straight after reset
    c0 = checks;
    e0 = errors;
    @(negedge clk);
    cycle_check(1'b1, 1'b0, 1'b0);
    report("reset", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 200 && !timed_out; i++) alu_op(1'b0, 1'b0);
    report("alu", c0, e0);

    // Branch in EX overrides stalls on ex_ready_o
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 100 && !timed_out; i++) alu_op(1'b1, 1'b1);
    report("branch", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 150 && !timed_out; i++) mult_op(1'b0);
    report("mult", c0, e0);

    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 50 && !timed_out; i++) csr_op(1'b0);
    report("csr", c0, e0);

    // Mixed ops under random WB stalls
    c0 = checks;
    e0 = errors;
    for (int i = 0; i < 200 && !timed_out; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    csr_op(1'b1);
        2'd1:    mult_op(1'b1);
        default: alu_op(1'b1, 1'b0);
      endcase
    end
    report("backpressure", c0, e0);

    $display("Summary: %0d checks, %0d errors, timeout %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ex_stage.f */
+incdir+rtl
+incdir+testbench
rtl/ex_op_pkg.sv
rtl/ex_wb_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_commit.sv
rtl/ex_stage.sv
testbench/tb_ex_stage.sv

/* Makefile */
# Verilator build and run of the ex_stage testbench
TOP := tb_ex_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f ex_stage.f -Mdir obj_dir

# Pass only if the log holds the pass line
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@grep -F -q '*** TEST PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
